/* design/cpu_consts.svh */
/*
 * Sizing constants for the SAP-1 style accumulator CPU.
 * Included by the package and by every block that sizes a bus,
 * a memory or the T-state counter.
 */

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Bus, accumulator and register width
`define CPU_DATA_W 8

// RAM address width, also the PC width
`define CPU_ADDR_W 4

// RAM depth in bytes
`define CPU_RAM_WORDS 16

// Micro-steps per instruction, T0 to T4
`define CPU_T_STATES 5

`endif

/* design/cpu_pkg.sv */
/*
 * Shared types for the accumulator CPU: data word, RAM address,
 * opcode encoding and the T-state names used by the sequencer.
 * Blocks pull these in with a wildcard import in the module header.
 */

`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t; // One bus byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t; // RAM address / PC value

    // High nibble of the instruction byte
    typedef enum logic [3:0] {
        LDA = 4'h0, // A <= RAM[operand]
        ADD = 4'h1, // A <= A + RAM[operand]
        SUB = 4'h2, // A <= A - RAM[operand]
        STA = 4'h3, // RAM[operand] <= A
        LDI = 4'h4, // A <= operand
        JMP = 4'h5, // PC <= operand
        JC  = 4'h6, // Jump if carry
        JZ  = 4'h7, // Jump if zero
        OUT = 4'hE, // Output register <= A
        HLT = 4'hF  // Stop the sequencer
    } opcode_e;

    // Micro-steps of one instruction
    typedef enum logic [2:0] {
        T0 = 3'd0, // PC to MAR
        T1 = 3'd1, // RAM to IR, PC + 1
        T2 = 3'd2, // Execute steps
        T3 = 3'd3,
        T4 = 3'd4
    } t_state_e;

endpackage

/* design/ctrl_if.sv */
/*
 * Control word from the sequencer to the datapath, memory unit and
 * output port. All bits are active high; one modport per consumer.
 */

interface ctrl_if;

    logic pc_inc, pc_out, pc_load;   // Program counter
    logic mar_load, ram_out, ram_in; // Memory address register and RAM
    logic ir_load, ir_out;           // Instruction register
    logic a_load, a_out;             // Accumulator
    logic alu_sub, alu_out;          // ALU mode and bus drive
    logic b_load;                    // B register
    logic out_load;                  // Output register
    logic halt;                      // HLT reached

    modport seq (
        output pc_inc, pc_out, pc_load, mar_load, ram_out, ram_in,
               ir_load, ir_out, a_load, a_out, alu_sub, alu_out,
               b_load, out_load, halt
    );

    // Datapath owns the bus mux and all registers except MAR and output
    modport dp (
        input pc_inc, pc_out, pc_load, ram_out, ir_load, ir_out,
              a_load, a_out, alu_sub, alu_out, b_load
    );

    modport mem  (input mar_load, ram_in);
    modport outp (input out_load, halt);

endinterface

/* design/memory_unit.sv */
/*
 * Input side of the CPU: program loader, MAR and the 16-byte RAM.
 * With run low the host writes bytes through the loader port;
 * with run high the MAR and RAM follow the control word.
 */

`include "cpu_consts.svh"

module memory_unit import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,       // Low = loader owns the RAM
    input  logic  wr_strobe, // One pulse per loaded byte
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  word_t bus,       // Internal bus from the datapath
    ctrl_if.mem   ctrl,
    output word_t ram_data   // Combinational read at the MAR
);

    word_t ram [`CPU_RAM_WORDS]; // Program and data storage
    addr_t mar;                  // Memory address register
    logic  load_we;              // Loader write this cycle
    logic  run_we;               // STA write this cycle

    assign load_we = !run && wr_strobe;
    assign run_we  = run && ctrl.ram_in;

    // MAR takes the low nibble of the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (!run) begin
            mar <= '0; // Held at 0 while loading
        end else if (ctrl.mar_load) begin
            mar <= addr_t'(bus[`CPU_ADDR_W-1:0]);
        end
    end

    // RAM comes up all zero, so an empty program runs as NOPs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_RAM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (load_we) begin
            ram[wr_addr] <= wr_data; // Host program load
        end else if (run_we) begin
            ram[mar] <= bus;         // STA from the accumulator
        end
    end

    assign ram_data = ram[mar];

    // Host must keep the loader quiet once the CPU is running
    a_no_load_while_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_strobe |-> !run
    ) else $error("loader strobe while run is high");

endmodule

/* design/datapath.sv */
/*
 * CPU datapath: one-hot bus mux, program counter, instruction
 * register, A and B registers, adder/subtractor and the carry and
 * zero flags. Controlled by the ctrl_if dp modport.
 */

`include "cpu_consts.svh"

module datapath import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    run,      // Low clears the PC
    ctrl_if.dp      ctrl,
    input  word_t   ram_data, // RAM read at the MAR
    output word_t   bus,      // Internal bus, 0 when nobody drives
    output opcode_e opcode,   // To the sequencer
    output logic    carry,
    output logic    zero
);

    addr_t pc;     // Program counter
    word_t ir;     // Instruction register
    word_t a_reg;  // Accumulator
    word_t b_reg;  // ALU second operand
    word_t pc_ext; // PC zero-extended to bus width
    word_t ir_arg; // Operand nibble zero-extended
    word_t b_op;   // B or its inverse for SUB
    word_t alu_res;
    logic [`CPU_DATA_W:0] alu_sum; // Extra bit is the carry out
    logic  alu_wr;                 // ALU result written to A

    assign pc_ext = word_t'(pc);
    assign ir_arg = word_t'(ir[`CPU_ADDR_W-1:0]);

    // One-hot AND-OR mux; all zero gives a zero bus
    always_comb begin
        bus = ({`CPU_DATA_W{ctrl.pc_out}}  & pc_ext)
            | ({`CPU_DATA_W{ctrl.ram_out}} & ram_data)
            | ({`CPU_DATA_W{ctrl.ir_out}}  & ir_arg)
            | ({`CPU_DATA_W{ctrl.a_out}}   & a_reg)
            | ({`CPU_DATA_W{ctrl.alu_out}} & alu_res);
    end

    // SUB is A + ~B + 1, carry set means no borrow
    assign b_op    = ctrl.alu_sub ? ~b_reg : b_reg;
    assign alu_sum = {1'b0, a_reg} + {1'b0, b_op}
                   + {{`CPU_DATA_W{1'b0}}, ctrl.alu_sub};
    assign alu_res = alu_sum[`CPU_DATA_W-1:0];
    assign alu_wr  = ctrl.alu_out && ctrl.a_load;

    // Program counter, jump wins over increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0; // Next run starts at address 0
        end else if (ctrl.pc_load) begin
            pc <= addr_t'(bus[`CPU_ADDR_W-1:0]);
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1; // Wraps at 16
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= bus;
        end
    end

    // Accumulator and B hold plain data
    always_ff @(posedge clk) begin
        if (ctrl.a_load) begin
            a_reg <= bus;
        end
        if (ctrl.b_load) begin
            b_reg <= bus;
        end
    end

    // Flags move only on ADD/SUB write-back, LDA and LDI leave them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (alu_wr) begin
            carry <= alu_sum[`CPU_DATA_W];
            zero  <= (alu_res == '0);
        end
    end

    assign opcode = opcode_e'(ir[`CPU_DATA_W-1:`CPU_ADDR_W]); // High nibble

    // Bus drivers come from the sequencer decode, at most one per cycle
    a_bus_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.pc_out, ctrl.ram_out, ctrl.ir_out, ctrl.a_out, ctrl.alu_out})
    ) else $error("more than one bus source enabled");

endmodule

/* design/control_sequencer.sv */
/*
 * T-state counter and microcode decode. Every instruction runs
 * T0..T4; T0/T1 fetch, T2..T4 execute by opcode. HLT freezes the
 * counter until run drops.
 */

`include "cpu_consts.svh"

module control_sequencer import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    run,    // Low holds the CPU at T0
    input  opcode_e opcode, // From the IR
    input  logic    carry,
    input  logic    zero,
    ctrl_if.seq     ctrl
);

    t_state_e t_state;
    logic     halted_q; // Sequencer stopped on HLT
    logic     active;   // Decode enabled
    logic     last_t;   // Final micro-step

    assign active = run && !halted_q;
    assign last_t = (t_state == t_state_e'(`CPU_T_STATES - 1));

    // Step counter; halt holds it where it stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_state <= T0;
        end else if (!run) begin
            t_state <= T0;
        end else if (active && !ctrl.halt) begin
            t_state <= last_t ? T0 : t_state_e'(t_state + 3'd1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_q <= 1'b0;
        end else if (!run) begin
            halted_q <= 1'b0; // Cleared for the next program
        end else if (ctrl.halt) begin
            halted_q <= 1'b1;
        end
    end

    // Microcode with all controls active high
    always_comb begin
        ctrl.pc_inc   = 1'b0;
        ctrl.pc_out   = 1'b0;
        ctrl.pc_load  = 1'b0;
        ctrl.mar_load = 1'b0;
        ctrl.ram_out  = 1'b0;
        ctrl.ram_in   = 1'b0;
        ctrl.ir_load  = 1'b0;
        ctrl.ir_out   = 1'b0;
        ctrl.a_load   = 1'b0;
        ctrl.a_out    = 1'b0;
        ctrl.alu_sub  = 1'b0;
        ctrl.alu_out  = 1'b0;
        ctrl.b_load   = 1'b0;
        ctrl.out_load = 1'b0;
        ctrl.halt     = 1'b0;
        if (active) begin
            unique case (t_state)
                T0: begin // Fetch address
                    ctrl.pc_out   = 1'b1;
                    ctrl.mar_load = 1'b1;
                end
                T1: begin // Fetch opcode
                    ctrl.ram_out = 1'b1;
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                T2: begin
                    case (opcode)
                        LDA, ADD, SUB, STA: begin // Operand address to MAR
                            ctrl.ir_out   = 1'b1;
                            ctrl.mar_load = 1'b1;
                        end
                        LDI: begin
                            ctrl.ir_out = 1'b1;
                            ctrl.a_load = 1'b1;
                        end
                        JMP, JC, JZ: begin
                            ctrl.ir_out  = (opcode == JMP) || (opcode == JC && carry)
                                        || (opcode == JZ && zero);
                            ctrl.pc_load = ctrl.ir_out; // Skipped jump is a NOP
                        end
                        OUT: begin
                            ctrl.a_out    = 1'b1;
                            ctrl.out_load = 1'b1;
                        end
                        HLT: ctrl.halt = 1'b1;
                        default: ;                // Unused opcodes do nothing
                    endcase
                end
                T3: begin
                    case (opcode)
                        LDA: begin
                            ctrl.ram_out = 1'b1;
                            ctrl.a_load  = 1'b1;
                        end
                        ADD, SUB: begin // Operand into B
                            ctrl.ram_out = 1'b1;
                            ctrl.b_load  = 1'b1;
                        end
                        STA: begin
                            ctrl.a_out  = 1'b1;
                            ctrl.ram_in = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    if (opcode == ADD || opcode == SUB) begin
                        ctrl.alu_sub = (opcode == SUB);
                        ctrl.alu_out = 1'b1;
                        ctrl.a_load  = 1'b1; // Result back to A with a flag update
                    end
                end
                default: ;
            endcase
        end
    end

    a_halt_no_inc: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.halt && ctrl.pc_inc)
    ) else $error("halt together with PC increment");

endmodule

/* design/output_port.sv */
/*
 * Output side: output register loaded by OUT, a one-cycle valid
 * strobe that lines up with the new value, and the halted level.
 */

module output_port import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,       // Low clears halted
    input  word_t bus,
    ctrl_if.outp  ctrl,
    output word_t out_value, // Drives uo_out
    output logic  out_valid, // High the cycle after a load
    output logic  halted
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_value <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_load; // Same edge as the new value
            if (ctrl.out_load) begin
                out_value <= bus;
            end
        end
    end

    // Sticky until the host drops run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (!run) begin
            halted <= 1'b0;
        end else if (ctrl.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

/* design/sap_cpu_top.sv */
/*
 * Pin-frame top of the accumulator CPU. ui_in and uio_in feed the
 * program loader and run level; uo_out shows the output register,
 * uio_out[1:0] carry out_valid and halted.
 */

`include "cpu_consts.svh"

module sap_cpu_top (
    input  logic [7:0] ui_in,   // Program byte
    output logic [7:0] uo_out,  // Output register
    input  logic [7:0] uio_in,  // [0] run, [1] write strobe, [7:4] address
    output logic [7:0] uio_out, // [0] halted, [1] out_valid
    output logic [7:0] uio_oe,
    input  logic       ena,     // Not used
    input  logic       clk,
    input  logic       rst_n
);

    logic [`CPU_DATA_W-1:0] bus;      // Internal bus
    logic [`CPU_DATA_W-1:0] ram_data; // RAM read back to the mux
    logic [`CPU_DATA_W-1:0] out_value;
    cpu_pkg::opcode_e       opcode;
    logic                   carry;
    logic                   zero;
    logic                   out_valid;
    logic                   halted;
    logic                   run;

    assign run = uio_in[0];

    ctrl_if ctrl ();

    memory_unit memory_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .wr_strobe (uio_in[1]),
        .wr_addr   (uio_in[7 -: `CPU_ADDR_W]),
        .wr_data   (ui_in),
        .bus       (bus),
        .ctrl      (ctrl.mem),
        .ram_data  (ram_data)
    );

    datapath datapath_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .ctrl     (ctrl.dp),
        .ram_data (ram_data),
        .bus      (bus),
        .opcode   (opcode),
        .carry    (carry),
        .zero     (zero)
    );

    control_sequencer control_sequencer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .opcode (opcode),
        .carry  (carry),
        .zero   (zero),
        .ctrl   (ctrl.seq)
    );

    output_port output_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .bus       (bus),
        .ctrl      (ctrl.outp),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted)
    );

    assign uo_out  = out_value;
    assign uio_out = {6'b0, out_valid, halted};
    assign uio_oe  = 8'h03; // Only the two status bits are outputs

endmodule

/* dv/sap_cpu_tb.sv */
/*
 * Directed testbench for the accumulator CPU pin frame. Programs are
 * loaded through ui_in/uio_in with run low, then run to HLT; every
 * out_valid value is compared with an instruction-level model.
 */

module sap_cpu_tb;

    localparam int RUN_LIMIT = 4000; // Cycles allowed for any wait

    // Opcode encoding in the high nibble of the instruction byte
    localparam logic [3:0] OP_LDA = 4'h0;
    localparam logic [3:0] OP_ADD = 4'h1;
    localparam logic [3:0] OP_SUB = 4'h2;
    localparam logic [3:0] OP_STA = 4'h3;
    localparam logic [3:0] OP_LDI = 4'h4;
    localparam logic [3:0] OP_JMP = 4'h5;
    localparam logic [3:0] OP_JC  = 4'h6;
    localparam logic [3:0] OP_JZ  = 4'h7;
    localparam logic [3:0] OP_OUT = 4'hE;
    localparam logic [3:0] OP_HLT = 4'hF;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;  // [0] run, [1] strobe, [7:4] address
    logic [7:0] uo_out;
    logic [7:0] uio_out; // [0] halted, [1] out_valid
    logic [7:0] uio_oe;

    logic [7:0] image [16]; // Memory image for loader and model
    logic [7:0] exp_q [$];  // Model output sequence
    logic [7:0] got_q [$];  // Values seen with out_valid

    sap_cpu_top sap_cpu_top_i (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [7:0] encode(input logic [3:0] op, input logic [3:0] arg);
        return {op, arg};
    endfunction

    task automatic clear_image();
        for (int i = 0; i < 16; i++) begin
            image[i] = encode(OP_HLT, 4'h0); // Stray fetch stops the CPU
        end
    endtask

    // Instruction-level model of the ISA over a copy of the image
    task automatic model_program();
        logic [7:0] mem [16];
        logic [7:0] a;
        logic [7:0] b;
        logic [8:0] sum;
        logic [3:0] pc;
        logic [3:0] arg;
        logic       carry;
        logic       zero;
        logic       done;
        int         steps;
        mem   = image;
        a     = 8'h00;
        pc    = 4'h0;
        carry = 1'b0;
        zero  = 1'b0;
        done  = 1'b0;
        steps = 0;
        exp_q.delete();
        while (!done) begin
            if (steps == 256) stop_on_error("model ran 256 instructions without HLT");
            arg = mem[pc][3:0];
            b   = mem[arg];
            case (mem[pc][7:4])
                OP_LDA: a = b;
                OP_ADD: begin
                    sum   = {1'b0, a} + {1'b0, b}; // Carry is bit 8
                    a     = sum[7:0];
                    carry = sum[8];
                    zero  = (a == 8'h00);
                end
                OP_SUB: begin
                    carry = (a >= b); // Set when no borrow
                    a     = a - b;
                    zero  = (a == 8'h00);
                end
                OP_STA: mem[arg] = a;
                OP_LDI: a = {4'h0, arg};
                OP_OUT: exp_q.push_back(a);
                OP_HLT: done = 1'b1;
                default: ; // Jumps are handled below and the rest are NOPs
            endcase
            pc = pc + 4'd1;
            if (mem[pc - 4'd1][7:4] == OP_JMP
                || (mem[pc - 4'd1][7:4] == OP_JC && carry)
                || (mem[pc - 4'd1][7:4] == OP_JZ && zero)) begin
                pc = arg;
            end
            steps++;
        end
    endtask

    // One strobe per byte with run held low
    task automatic load_program();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            ui_in  <= image[i];
            uio_in <= {4'(i), 2'b00, 1'b1, 1'b0};
            @(posedge clk);
            uio_in <= {4'(i), 2'b00, 1'b0, 1'b0};
        end
    endtask

    task automatic run_and_collect();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        got_q.delete();
        @(posedge clk);
        uio_in <= 8'h01; // Run high with the loader idle
        while (!done) begin
            @(negedge clk);
            if (uio_out[1] === 1'b1) got_q.push_back(uo_out); // No back-pressure
            done = (uio_out[0] === 1'b1);
            cycles++;
            if (!done && cycles > RUN_LIMIT) stop_on_error("timeout waiting for halted");
        end
    endtask

    // Drop run and wait for halted to clear
    task automatic drop_run();
        int cycles;
        cycles = 0;
        @(posedge clk);
        uio_in <= 8'h00;
        @(negedge clk);
        while (uio_out[0] !== 1'b0) begin
            cycles++;
            if (cycles > 8) stop_on_error("halted stayed high after run dropped");
            @(negedge clk);
        end
    endtask

    task automatic run_program(input string tag);
        model_program();
        load_program();
        run_and_collect();
        check({tag, " out_valid count"}, 8'(got_q.size()), 8'(exp_q.size()));
        for (int i = 0; i < exp_q.size(); i++) begin
            check($sformatf("%s uo_out[%0d]", tag, i), got_q[i], exp_q[i]);
        end
        repeat (3) @(negedge clk); // Run stays high after HLT
        check({tag, " halted held"}, {7'b0, uio_out[0]}, 8'h01);
        check({tag, " out_valid after HLT"}, {7'b0, uio_out[1]}, 8'h00);
        if (exp_q.size() > 0) begin
            check({tag, " uo_out hold"}, uo_out, exp_q[exp_q.size() - 1]);
        end
        drop_run(); // Next program starts from address 0
    endtask

    task automatic arith_test();
        for (int n = 0; n < 4; n++) begin
            clear_image();
            image[0]  = encode(OP_LDA, 4'hD);
            image[1]  = encode(OP_ADD, 4'hE);
            image[2]  = encode(OP_OUT, 4'h0);
            image[3]  = encode(OP_SUB, 4'hF);
            image[4]  = encode(OP_OUT, 4'h0);
            image[5]  = encode(OP_LDI, 4'($urandom));
            image[6]  = encode(OP_ADD, 4'hD);
            image[7]  = encode(OP_OUT, 4'h0);
            image[8]  = encode(OP_HLT, 4'h0);
            image[13] = 8'($urandom); // Random operands
            image[14] = 8'($urandom);
            image[15] = 8'($urandom);
            run_program("arith");
        end
    endtask

    // Zero path outputs 1, carry path 2, fall-through 3
    task automatic jump_case(input logic [3:0] op, input logic [7:0] p, input logic [7:0] q);
        clear_image();
        image[0]  = encode(OP_LDA, 4'hE);
        image[1]  = encode(op, 4'hF);
        image[2]  = encode(OP_JZ, 4'h7);
        image[3]  = encode(OP_JC, 4'h9);
        image[4]  = encode(OP_LDI, 4'h3);
        image[5]  = encode(OP_OUT, 4'h0);
        image[6]  = encode(OP_HLT, 4'h0);
        image[7]  = encode(OP_LDI, 4'h1);
        image[8]  = encode(OP_JMP, 4'h5);
        image[9]  = encode(OP_LDI, 4'h2);
        image[10] = encode(OP_JMP, 4'h5);
        image[14] = p;
        image[15] = q;
        run_program("jump");
    endtask

    task automatic jump_test();
        logic [7:0] p;
        p = 8'($urandom_range(200, 20));
        jump_case(OP_SUB, p, p);                 // Exactly zero
        jump_case(OP_SUB, p, p - 8'd7);          // No borrow
        jump_case(OP_SUB, p - 8'd9, p);          // Borrow
        jump_case(OP_ADD, p, 8'd0 - p);          // Wraps to zero with carry
        jump_case(OP_ADD, 8'hF0, 8'h20);         // Carry only
        jump_case(OP_ADD, 8'h10, 8'h20);         // Neither flag
    endtask

    task automatic memory_test();
        clear_image();
        image[0]  = encode(OP_LDA, 4'hF); // Loader-written constant
        image[1]  = encode(OP_OUT, 4'h0);
        image[2]  = encode(OP_ADD, 4'hE);
        image[3]  = encode(OP_STA, 4'hC);
        image[4]  = encode(OP_LDI, 4'h0);
        image[5]  = encode(OP_LDA, 4'hC); // Read back the stored sum
        image[6]  = encode(OP_OUT, 4'h0);
        image[7]  = encode(OP_HLT, 4'h0);
        image[14] = 8'($urandom);
        image[15] = 8'($urandom);
        run_program("memory");
    endtask

    // Count down from image[15] by image[14] and leave through JZ
    task automatic loop_image(input logic [7:0] start);
        clear_image();
        image[0]  = encode(OP_LDA, 4'hF);
        image[1]  = encode(OP_OUT, 4'h0);
        image[2]  = encode(OP_SUB, 4'hE);
        image[3]  = encode(OP_JZ, 4'h5);
        image[4]  = encode(OP_JMP, 4'h1);
        image[5]  = encode(OP_OUT, 4'h0);
        image[6]  = encode(OP_HLT, 4'h0);
        image[14] = 8'h01;
        image[15] = start;
    endtask

    task automatic loop_test();
        loop_image(8'($urandom_range(7, 2)));
        run_program("loop");
    endtask

    task automatic restart_test();
        int cycles;
        cycles = 0;
        // Back-to-back programs; each run_program drops run and reloads
        memory_test();
        arith_test();
        loop_image(8'hA5); // Long loop so the reset lands mid-run
        load_program();
        @(posedge clk);
        uio_in <= 8'h01;
        @(negedge clk);
        while (uio_out[1] !== 1'b1) begin
            cycles++;
            if (cycles > RUN_LIMIT) stop_on_error("no out_valid before mid-run reset");
            @(negedge clk);
        end
        check("uo_out before reset", uo_out, 8'hA5);
        // Four instructions later the loop OUT loads 8'hA4 on this edge
        repeat (20) @(posedge clk);
        rst_n  <= 1'b0;
        uio_in <= 8'h00;
        @(negedge clk);
        check("uo_out in reset", uo_out, 8'h00);
        check("uio_out in reset", uio_out, 8'h00);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("uio_out after reset", uio_out, 8'h00);
        memory_test(); // CPU runs again after the reset
    endtask

    initial begin
        void'($urandom(32'hb1e1));
        rst_n  = 1'b0;
        ena    = 1'b1;
        ui_in  = 8'h00;
        uio_in = 8'h00;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("uo_out", uo_out, 8'h00);
        check("uio_out", uio_out, 8'h00);
        check("uio_oe", uio_oe, 8'h03);
        arith_test();
        jump_test();
        memory_test();
        loop_test();
        restart_test();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/cpu_pkg.sv
design/ctrl_if.sv
design/memory_unit.sv
design/datapath.sv
design/control_sequencer.sv
design/output_port.sv
design/sap_cpu_top.sv
dv/sap_cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, then run it; the exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sap_cpu_tb \
    -f compile.f -o sap_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sap_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
fi
exit "$status"
